/* include/wfd_consts.svh */
`ifndef WFD_CONSTS_SVH
`define WFD_CONSTS_SVH

////////////////////////////////////////
// Link geometry
////////////////////////////////////////

// Receive and transmit lanes on the board
`define WFD_LANES 4

// Parallel word per lane
`define WFD_LANE_W 16

////////////////////////////////////////
// Serial trigger token
////////////////////////////////////////

// Token number width
`define WFD_TOKEN_W 10

// Start bit, token bits, even parity
`define WFD_FRAME_BITS 12

// Idle word sent as a K-character
`define WFD_COMMA 16'h00BC

// Heads every token word on the lanes
`define WFD_TOK_MARK 5'b10000

////////////////////////////////////////
// Front panel
////////////////////////////////////////

// Cycles a LED stays lit after its last pulse
`define WFD_LED_STRETCH 16

`endif

/* src/gtp_lane_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wfd_consts.svh"

module gtp_lane_monitor
	import wfd_pkg::*;
(
	input wire CLK125,
	input wire reset_i,
	input wire lane_word_t [`WFD_LANES-1:0] rx_data_i,
	input wire lane_flags_t rx_kchar_i,
	output lane_flags_t tp_o,
	output lane_flags_t data_seen_o
);

	// First test point stage
	lane_flags_t tp_q;

	////////////////////////////////////////
	// Per-lane classification
	////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			tp_q <= '0;
			tp_o <= '0;
			data_seen_o <= '0;
		end else begin
			for (int i = 0; i < `WFD_LANES; i++) begin
				// Top data bit of a K-character
				tp_q[i] <= rx_data_i[i][`WFD_LANE_W-1] & rx_kchar_i[i];
			end
			// Second stage onto the test points
			tp_o <= tp_q;
			// Anything not a K-character is a data word
			data_seen_o <= ~rx_kchar_i;
		end
	end

	// Both stages start out clear after reset
	a_tp_clear: assert property (@(posedge CLK125)
		$fell(reset_i) |-> (tp_o == '0) ##1 (tp_o == '0));

endmodule

`default_nettype wire

/* src/led_indicator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wfd_consts.svh"

module led_indicator
	import wfd_pkg::*;
(
	input wire CLK125,
	input wire reset_i,
	input wire tok_rdy_i,
	input wire tok_err_i,
	input wire lane_flags_t data_seen_i,
	input wire inhibit_n_i,
	output logic [3:0] led_o
);

	localparam int CNT_W = $clog2(`WFD_LED_STRETCH + 1);

	logic [3:0] led_src;

	////////////////////////////////////////
	// LED sources
	////////////////////////////////////////

	// Yellow, token error
	assign led_src[0] = tok_err_i;
	// Data word on any lane
	assign led_src[1] = |data_seen_i;
	// Token received
	assign led_src[2] = tok_rdy_i;
	// No inhibit
	assign led_src[3] = inhibit_n_i;

	////////////////////////////////////////
	// Stretchers
	////////////////////////////////////////

	for (genvar i = 0; i < 4; i++) begin : g_led
		logic [CNT_W-1:0] hold_cnt;

		always_ff @(posedge CLK125) begin
			// Source wins, so LED3 keeps following inhibit through reset
			if (led_src[i])
				hold_cnt <= CNT_W'(`WFD_LED_STRETCH);
			else if (reset_i)
				hold_cnt <= '0;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end

		// Lit while the hold runs
		assign led_o[i] = (hold_cnt != '0);

		// Full hold with a quiet source leaves the LED dark
		a_led_dark: assert property (@(posedge CLK125) disable iff (reset_i)
			(!led_src[i]) [*`WFD_LED_STRETCH + 1] |-> !led_o[i]);
	end

endmodule

`default_nettype wire

/* src/trig_token_rcv.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wfd_consts.svh"

module trig_token_rcv
	import wfd_pkg::*;
(
	input wire CLK125,
	input wire reset_i,
	input wire ser_trig_i,
	output logic tok_rdy_o,
	output logic tok_err_o,
	output tx_word_u tx_word_o,
	output logic tx_kchar_o
);

	// Counter runs 1 .. FRAME_BITS-1 inside a frame, 0 when idle
	localparam int CNT_W = $clog2(`WFD_FRAME_BITS);
	localparam logic [CNT_W-1:0] PAR_IDX = CNT_W'(`WFD_FRAME_BITS - 1);

	logic [CNT_W-1:0] bit_cnt;
	token_t shift_q;
	logic par_q;

	////////////////////////////////////////
	// Deframer control
	////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			bit_cnt <= '0;
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
		end else begin
			// Strobes last one cycle
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
			if (bit_cnt == '0) begin
				// Line idles low, high sample is the start bit
				if (ser_trig_i)
					bit_cnt <= CNT_W'(1);
			end else if (bit_cnt == PAR_IDX) begin
				// Parity sample, token complete
				bit_cnt <= '0;
				tok_rdy_o <= 1'b1;
				// Even parity over token bits and parity bit
				tok_err_o <= par_q ^ ser_trig_i;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Token shift and running parity
	////////////////////////////////////////

	// Shift stops once the token is in
	// Holds the token through the pulse cycle
	always_ff @(posedge CLK125) begin
		if (bit_cnt == '0) begin
			par_q <= 1'b0;
		end else if (bit_cnt != PAR_IDX) begin
			// MSB first
			shift_q <= {shift_q[`WFD_TOKEN_W-2:0], ser_trig_i};
			par_q <= par_q ^ ser_trig_i;
		end
	end

	////////////////////////////////////////
	// Transmit word encoder
	////////////////////////////////////////

	always_comb begin
		// Idle comma between tokens
		tx_word_o.raw = `WFD_COMMA;
		if (tok_rdy_o) begin
			tx_word_o.tok.mark = `WFD_TOK_MARK;
			tx_word_o.tok.err = tok_err_o;
			tx_word_o.tok.token = shift_q;
		end
	end

	// Data character only while the token goes out
	assign tx_kchar_o = ~tok_rdy_o;

	// Error flag only rides on a token
	a_err_with_rdy: assert property (@(posedge CLK125) disable iff (reset_i)
		$rose(tok_err_o) |-> tok_rdy_o);

	// K-character cycles carry the comma, data cycles carry the token marker
	a_kchar_word: assert property (@(posedge CLK125) disable iff (reset_i)
		tx_kchar_o ? (tx_word_o.raw == `WFD_COMMA)
			: (tx_word_o.tok.mark == `WFD_TOK_MARK));

endmodule

`default_nettype wire

/* src/wfd_link_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wfd_consts.svh"

module wfd_link_top
	import wfd_pkg::*;
(
	input wire CLK125,
	input wire reset_i,
	input wire ser_trig_i,
	input wire inhibit_n_i,
	input wire lane_word_t [`WFD_LANES-1:0] rx_data_i,
	input wire lane_flags_t rx_kchar_i,
	output tx_word_u tx_word_o,
	output logic tx_kchar_o,
	output lane_flags_t tp_o,
	output logic [3:0] led_o
);

	// Token strobes to the LEDs
	logic tok_rdy;
	logic tok_err;
	// Per-lane data word flags
	lane_flags_t data_seen;

	////////////////////////////////////////
	// Trigger token capture and broadcast
	////////////////////////////////////////

	// Same word and K-flag go out on every lane
	trig_token_rcv u_trig_token_rcv (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.ser_trig_i(ser_trig_i),
		.tok_rdy_o(tok_rdy),
		.tok_err_o(tok_err),
		.tx_word_o(tx_word_o),
		.tx_kchar_o(tx_kchar_o)
	);

	// Receive lanes
	gtp_lane_monitor u_gtp_lane_monitor (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.rx_data_i(rx_data_i),
		.rx_kchar_i(rx_kchar_i),
		.tp_o(tp_o),
		.data_seen_o(data_seen)
	);

	// Front panel
	led_indicator u_led_indicator (
		.CLK125(CLK125),
		.reset_i(reset_i),
		.tok_rdy_i(tok_rdy),
		.tok_err_i(tok_err),
		.data_seen_i(data_seen),
		.inhibit_n_i(inhibit_n_i),
		.led_o(led_o)
	);

endmodule

`default_nettype wire

/* src/wfd_pkg.sv */
`default_nettype none

`include "wfd_consts.svh"

package wfd_pkg;

	////////////////////////////////////////
	// Basic words
	////////////////////////////////////////

	// Token number as received from the trigger line
	typedef logic [`WFD_TOKEN_W-1:0] token_t;

	// One lane word, receive or transmit
	typedef logic [`WFD_LANE_W-1:0] lane_word_t;

	// One bit per lane
	typedef logic [`WFD_LANES-1:0] lane_flags_t;

	////////////////////////////////////////
	// Transmit word
	////////////////////////////////////////

	// Token word layout, marker on top
	typedef struct packed {
		logic [`WFD_LANE_W-`WFD_TOKEN_W-2:0] mark;
		logic err;
		token_t token;
	} tok_word_s;

	// Same 16 bits seen two ways
	// Token view while a token goes out, raw view for the comma
	typedef union packed {
		tok_word_s tok;
		lane_word_t raw;
	} tx_word_u;

endpackage

`default_nettype wire

/* verif/wfd_link_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "wfd_consts.svh"

module wfd_link_tb
	import wfd_pkg::*;
();

	localparam int NROWS = 8;
	// Each row takes under 40 cycles
	localparam int CYCLE_LIMIT = NROWS * 40 + 200;

	logic CLK125;
	logic reset;
	logic ser_trig;
	logic inhibit_n;
	lane_word_t [`WFD_LANES-1:0] rx_data;
	lane_flags_t rx_kchar;
	tx_word_u tx_word;
	logic tx_kchar;
	lane_flags_t tp;
	logic [3:0] led;

	// Stimulus table, one row per token
	token_t tab_token [NROWS];
	logic tab_bad [NROWS];
	lane_word_t [`WFD_LANES-1:0] tab_data [NROWS];
	lane_flags_t tab_k [NROWS];
	logic tab_inh [NROWS];
	// Expected token word and test points per row
	tx_word_u tab_word [NROWS];
	lane_flags_t tab_tp [NROWS];

	// Expected-value state
	int tcyc;
	int last_src [4];
	logic data_pending;
	logic tok_pending;
	logic err_pending;
	logic exp_tok;
	tx_word_u exp_word;
	tx_word_u idle_word;
	// Test points due from the lane inputs now driven
	lane_flags_t tp_in;
	lane_flags_t tp_exp1;
	lane_flags_t tp_exp2;

	int errors;
	int checks;
	int cyc_cnt;

	wfd_link_top u_wfd_link_top (
		.CLK125(CLK125),
		.reset_i(reset),
		.ser_trig_i(ser_trig),
		.inhibit_n_i(inhibit_n),
		.rx_data_i(rx_data),
		.rx_kchar_i(rx_kchar),
		.tx_word_o(tx_word),
		.tx_kchar_o(tx_kchar),
		.tp_o(tp),
		.led_o(led)
	);

	////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////

	initial begin
		CLK125 = 1'b0;
		forever #10 CLK125 = ~CLK125;
	end

	initial begin
		cyc_cnt = 0;
		while (cyc_cnt < CYCLE_LIMIT) begin
			@(posedge CLK125);
			cyc_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_tx_word(input string name, input tx_word_u act, input tx_word_u exp);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h at cycle %0d",
				name, act.raw, exp.raw, tcyc);
			errors++;
		end
	endtask

	task automatic check_kchar(input string name, input logic act, input logic exp);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h at cycle %0d", name, act, exp, tcyc);
			errors++;
		end
	endtask

	task automatic check_flags(input string name, input lane_flags_t act,
		input lane_flags_t exp);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h at cycle %0d", name, act, exp, tcyc);
			errors++;
		end
	endtask

	task automatic check_led(input string name, input logic [3:0] act, input logic [3:0] exp);
		checks++;
		if (act !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h at cycle %0d", name, act, exp, tcyc);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Expected values
	////////////////////////////////////////

	// Bit 15 AND K per lane
	function automatic lane_flags_t tp_expect(input lane_word_t [`WFD_LANES-1:0] data,
		input lane_flags_t k);
		lane_flags_t f;
		for (int i = 0; i < `WFD_LANES; i++)
			f[i] = data[i][`WFD_LANE_W-1] & k[i];
		return f;
	endfunction

	// Lit for STRETCH cycles counted from the last edge that saw the source high
	function automatic logic [3:0] led_expect();
		logic [3:0] exp;
		int age;
		for (int i = 0; i < 4; i++) begin
			age = tcyc - last_src[i];
			exp[i] = (age >= 0) && (age < `WFD_LED_STRETCH);
		end
		return exp;
	endfunction

	task automatic check_outputs();
		if (exp_tok) begin
			check_tx_word("tx_word_o", tx_word, exp_word);
			check_kchar("tx_kchar_o", tx_kchar, 1'b0);
		end else begin
			check_tx_word("tx_word_o", tx_word, idle_word);
			check_kchar("tx_kchar_o", tx_kchar, 1'b1);
		end
		check_flags("tp_o", tp, tp_exp2);
		check_led("led_o", led, led_expect());
	endtask

	// One clock edge, then the checks 2 ns later
	task automatic clock_step();
		@(posedge CLK125);
		tcyc++;
		// Sources as the LED stretchers see them at this edge
		if (inhibit_n)
			last_src[3] = tcyc;
		if (data_pending)
			last_src[1] = tcyc;
		data_pending = !reset && (rx_kchar != '1);
		if (tok_pending) begin
			last_src[2] = tcyc;
			if (err_pending)
				last_src[0] = tcyc;
			tok_pending = 1'b0;
		end
		// Two-stage test point delay
		tp_exp2 = reset ? '0 : tp_exp1;
		tp_exp1 = reset ? '0 : tp_in;
		#2;
		check_outputs();
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Start bit, token MSB first, even parity
	task automatic send_frame(input token_t tok, input logic bad_par, input tx_word_u word);
		logic par;
		par = (^tok) ^ bad_par;
		ser_trig = 1'b1;
		clock_step();
		for (int i = `WFD_TOKEN_W - 1; i >= 0; i--) begin
			ser_trig = tok[i];
			clock_step();
		end
		ser_trig = par;
		// Token word expected right after the parity edge
		exp_tok = 1'b1;
		exp_word = word;
		clock_step();
		exp_tok = 1'b0;
		tok_pending = 1'b1;
		err_pending = bad_par;
		ser_trig = 1'b0;
	endtask

	task automatic apply_row(input int r);
		rx_data = tab_data[r];
		rx_kchar = tab_k[r];
		inhibit_n = tab_inh[r];
		tp_in = tab_tp[r];
		clock_step();
		// Lanes back to comma
		rx_data = {`WFD_LANES{`WFD_COMMA}};
		rx_kchar = '1;
		tp_in = '0;
		repeat (2) clock_step();
		send_frame(tab_token[r], tab_bad[r], tab_word[r]);
		// Let every LED run out
		repeat (24) clock_step();
	endtask

	task automatic fill_table();
		// Directed rows, lanes listed 3 down to 0
		tab_token[0] = 10'h155;
		tab_bad[0] = 1'b0;
		tab_data[0] = {16'h8000, 16'h0000, 16'h8000, 16'h8000};
		tab_k[0] = 4'b1111;
		tab_inh[0] = 1'b1;
		tab_word[0].raw = 16'h8155;
		tab_tp[0] = 4'b1011;
		tab_token[1] = 10'h2AA;
		tab_bad[1] = 1'b1;
		tab_data[1] = {16'h8001, 16'h1234, 16'hFFFF, 16'h00BC};
		tab_k[1] = 4'b0101;
		tab_inh[1] = 1'b1;
		tab_word[1].raw = 16'h86AA;
		tab_tp[1] = 4'b0000;
		tab_token[2] = 10'h000;
		tab_bad[2] = 1'b0;
		tab_data[2] = {16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF};
		tab_k[2] = 4'b1111;
		tab_inh[2] = 1'b0;
		tab_word[2].raw = 16'h8000;
		tab_tp[2] = 4'b1111;
		tab_token[3] = 10'h3FF;
		tab_bad[3] = 1'b1;
		tab_data[3] = {16'h8000, 16'h7FFF, 16'hC0DE, 16'h0001};
		tab_k[3] = 4'b0000;
		tab_inh[3] = 1'b0;
		tab_word[3].raw = 16'h87FF;
		tab_tp[3] = 4'b0000;
		// Random rows
		for (int r = 4; r < NROWS; r++) begin
			tab_token[r] = token_t'($urandom);
			tab_bad[r] = 1'($urandom);
			for (int l = 0; l < `WFD_LANES; l++)
				tab_data[r][l] = lane_word_t'($urandom);
			tab_k[r] = lane_flags_t'($urandom);
			tab_inh[r] = 1'($urandom);
			// Marker on top, then error flag and token
			tab_word[r].raw = {`WFD_TOK_MARK, tab_bad[r], tab_token[r]};
			tab_tp[r] = tp_expect(tab_data[r], tab_k[r]);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		ser_trig = 1'b0;
		inhibit_n = 1'b1;
		rx_data = {`WFD_LANES{`WFD_COMMA}};
		rx_kchar = '1;
		tcyc = 0;
		for (int i = 0; i < 4; i++)
			last_src[i] = -1000;
		data_pending = 1'b0;
		tok_pending = 1'b0;
		err_pending = 1'b0;
		exp_tok = 1'b0;
		idle_word.raw = `WFD_COMMA;
		exp_word = idle_word;
		tp_in = '0;
		tp_exp1 = '0;
		tp_exp2 = '0;
		errors = 0;
		checks = 0;
		void'($urandom(67239));
		fill_table();
		repeat (2) clock_step();
		reset = 1'b0;
		for (int r = 0; r < NROWS; r++)
			apply_row(r);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* wfd_link.f */
+incdir+include
src/wfd_pkg.sv
src/trig_token_rcv.sv
src/gtp_lane_monitor.sv
src/led_indicator.sv
src/wfd_link_top.sv
verif/wfd_link_tb.sv
